// File: Makefile
VERILATOR ?= verilator
TOP       ?= cce_dir_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= test passed

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  build  compile the testbench and RTL with Verilator"
	@echo "  test   build, run the simulation and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: common/cce_dir_consts.svh
`ifndef CCE_DIR_CONSTS_SVH
`define CCE_DIR_CONSTS_SVH

// Physical address split
`define CCE_PADDR_WIDTH 16
`define CCE_BLOCK_OFFSET 6
`define CCE_SET_WIDTH 3
`define CCE_TAG_WIDTH (`CCE_PADDR_WIDTH - `CCE_SET_WIDTH - `CCE_BLOCK_OFFSET)

// Geometry shared by every cache type
`define CCE_ASSOC 2
`define CCE_WAY_WIDTH 1

// LCE population
`define CCE_NUM_CORE 2
`define CCE_NUM_CACC 1
`define CCE_NUM_LCE ((2 * `CCE_NUM_CORE) + `CCE_NUM_CACC)
`define CCE_LCE_ID_WIDTH 3

// I$ and D$ ids come first, interleaved; A$ ids follow
`define CCE_ACC_LCE_BASE 4

`endif

// File: common/cce_dir_pkg.sv
package cce_dir_pkg;

  // Coherence state of one cached block
  typedef enum logic [2:0] {
    e_COH_I = 3'd0,
    e_COH_S = 3'd1,
    e_COH_E = 3'd2,
    e_COH_M = 3'd3,
    e_COH_O = 3'd4,
    e_COH_F = 3'd5
  } coh_state_e;

  // Directory operations
  typedef enum logic [1:0] {
    e_rdw_op = 2'd0,   // read way-group of one set
    e_rde_op = 2'd1,   // read one entry
    e_wde_op = 2'd2,   // write tag and state
    e_wds_op = 2'd3    // write state only
  } dir_op_e;

  // Destination register that an rde answer is tagged with
  typedef enum logic [2:0] {
    e_opd_r0 = 3'd0,
    e_opd_r1 = 3'd1,
    e_opd_r2 = 3'd2,
    e_opd_r3 = 3'd3,
    e_opd_r4 = 3'd4,
    e_opd_r5 = 3'd5,
    e_opd_r6 = 3'd6,
    e_opd_r7 = 3'd7
  } opd_gpr_e;

endpackage

// File: common/dir_seg_if.sv
`timescale 1ns/100ps
`include "cce_dir_consts.svh"

interface dir_seg_if #(
  parameter int seg_lce_p = 2
);
  localparam int lce_width_lp = (seg_lce_p > 1) ? $clog2(seg_lce_p) : 1;

  // Command
  logic [`CCE_PADDR_WIDTH-1:0]  addr;
  logic [lce_width_lp-1:0]      lce_local;
  logic [`CCE_WAY_WIDTH-1:0]    way;
  logic [`CCE_WAY_WIDTH-1:0]    lru_way;
  cce_dir_pkg::coh_state_e      coh_state;
  cce_dir_pkg::opd_gpr_e        addr_dst_gpr;
  cce_dir_pkg::dir_op_e         cmd;
  logic                         r_v;
  logic                         r_lru_v;
  logic                         w_v;

  // Response
  logic                                          busy;
  logic                                          sharers_v;
  logic [seg_lce_p-1:0]                          sharers_hits;
  logic [seg_lce_p-1:0][`CCE_WAY_WIDTH-1:0]      sharers_ways;
  cce_dir_pkg::coh_state_e [seg_lce_p-1:0]       sharers_states;
  logic                                          lru_v;
  cce_dir_pkg::coh_state_e                       lru_state;
  logic [`CCE_PADDR_WIDTH-1:0]                   lru_addr;
  logic                                          addr_v;
  logic [`CCE_PADDR_WIDTH-1:0]                   addr_out;
  cce_dir_pkg::opd_gpr_e                         addr_dst_gpr_out;

  modport ctrl (
    output addr, lce_local, way, lru_way, coh_state, addr_dst_gpr, cmd, r_v, r_lru_v, w_v,
    input  busy, sharers_v, sharers_hits, sharers_ways, sharers_states,
    input  lru_v, lru_state, lru_addr, addr_v, addr_out, addr_dst_gpr_out
  );

  modport seg (
    input  addr, lce_local, way, lru_way, coh_state, addr_dst_gpr, cmd, r_v, r_lru_v, w_v,
    output busy, sharers_v, sharers_hits, sharers_ways, sharers_states,
    output lru_v, lru_state, lru_addr, addr_v, addr_out, addr_dst_gpr_out
  );

endinterface

// File: dir_segment/dir_entry_store.sv
`timescale 1ns/100ps
`include "cce_dir_consts.svh"

module dir_entry_store #(
  parameter int seg_lce_p = 2,
  parameter int sets_p    = 8,
  localparam int set_w_lp = (sets_p > 1) ? $clog2(sets_p) : 1,
  localparam int lce_w_lp = (seg_lce_p > 1) ? $clog2(seg_lce_p) : 1
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,

  // Row read of all ways of one LCE in one set
  input  logic                                        rd_v_i,
  input  logic [set_w_lp-1:0]                         rd_set_i,
  input  logic [lce_w_lp-1:0]                         rd_lce_i,
  output logic [`CCE_ASSOC-1:0][`CCE_TAG_WIDTH-1:0]   rd_tags_o,
  output cce_dir_pkg::coh_state_e [`CCE_ASSOC-1:0]    rd_states_o,

  // Single-way write
  input  logic                                        wr_v_i,
  input  logic [set_w_lp-1:0]                         wr_set_i,
  input  logic [lce_w_lp-1:0]                         wr_lce_i,
  input  logic [`CCE_WAY_WIDTH-1:0]                   wr_way_i,
  input  logic                                        wr_tag_v_i,
  input  logic [`CCE_TAG_WIDTH-1:0]                   wr_tag_i,
  input  cce_dir_pkg::coh_state_e                     wr_state_i
);

  // One row per set and local LCE with the ways side by side
  logic [`CCE_ASSOC-1:0][`CCE_TAG_WIDTH-1:0] tag_mem   [sets_p][seg_lce_p];
  cce_dir_pkg::coh_state_e [`CCE_ASSOC-1:0]  state_mem [sets_p][seg_lce_p];

  // Reset leaves every entry in state I with a zero tag
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        for (int l = 0; l < seg_lce_p; l++) begin
          tag_mem[s][l] <= '0;
          for (int w = 0; w < `CCE_ASSOC; w++) begin
            state_mem[s][l][w] <= cce_dir_pkg::e_COH_I;
          end
        end
      end
    end else if (wr_v_i) begin
      state_mem[wr_set_i][wr_lce_i][wr_way_i] <= wr_state_i;
      // wds leaves the tag alone
      if (wr_tag_v_i) begin
        tag_mem[wr_set_i][wr_lce_i][wr_way_i] <= wr_tag_i;
      end
    end
  end

  // Row data arrives one cycle after the request
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      rd_tags_o   <= tag_mem[rd_set_i][rd_lce_i];
      rd_states_o <= state_mem[rd_set_i][rd_lce_i];
    end
  end

endmodule

// File: dir_segment/dir_segment.sv
`timescale 1ns/100ps
`include "cce_dir_consts.svh"

module dir_segment #(
  parameter int seg_lce_p = 2,
  parameter int sets_p    = 8
) (
  input  logic    clk_i,
  input  logic    reset_i,
  dir_seg_if.seg  seg_io
);

  localparam int set_w_lp = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int lce_w_lp = (seg_lce_p > 1) ? $clog2(seg_lce_p) : 1;

  typedef enum logic [1:0] {
    e_idle,
    e_read_group,
    e_read_entry,
    e_done_group
  } seg_state_e;

  seg_state_e                                 state_q;
  logic [lce_w_lp-1:0]                        cnt_q;
  logic                                       sharers_v_q;
  logic [seg_lce_p-1:0]                       hits_q;
  logic [seg_lce_p-1:0][`CCE_WAY_WIDTH-1:0]   ways_q;
  cce_dir_pkg::coh_state_e [seg_lce_p-1:0]    states_q;
  logic                                       lru_own_q;

  // Latched command operands
  logic [`CCE_TAG_WIDTH-1:0]  tag_q;
  logic [set_w_lp-1:0]        set_q;
  logic [lce_w_lp-1:0]        lce_q;
  logic [`CCE_WAY_WIDTH-1:0]  way_q;
  logic [`CCE_WAY_WIDTH-1:0]  lru_way_q;
  cce_dir_pkg::opd_gpr_e      gpr_q;
  logic [`CCE_TAG_WIDTH-1:0]  lru_tag_q;
  cce_dir_pkg::coh_state_e    lru_state_q;

  logic [`CCE_ASSOC-1:0][`CCE_TAG_WIDTH-1:0]  rd_tags;
  cce_dir_pkg::coh_state_e [`CCE_ASSOC-1:0]   rd_states;
  logic                                       row_hit;
  logic [`CCE_WAY_WIDTH-1:0]                  row_way;
  cce_dir_pkg::coh_state_e                    row_state;

  wire in_group   = (state_q == e_read_group);
  wire accept_rdw = seg_io.r_v && (seg_io.cmd == cce_dir_pkg::e_rdw_op);
  wire accept_rde = seg_io.r_v && (seg_io.cmd == cce_dir_pkg::e_rde_op);
  wire last_row   = (cnt_q == lce_w_lp'(seg_lce_p - 1));

  wire [`CCE_TAG_WIDTH-1:0] cmd_tag = seg_io.addr[`CCE_PADDR_WIDTH-1 -: `CCE_TAG_WIDTH];
  wire [set_w_lp-1:0]       cmd_set = seg_io.addr[`CCE_BLOCK_OFFSET +: set_w_lp];

  // rdw starts at row 0 on acceptance, then prefetches the next row each cycle
  dir_entry_store #(
    .seg_lce_p(seg_lce_p),
    .sets_p(sets_p)
  ) store_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rd_v_i(in_group ? !last_row : seg_io.r_v),
    .rd_set_i(in_group ? set_q : cmd_set),
    .rd_lce_i(in_group ? cnt_q + 1'b1 : (accept_rdw ? '0 : seg_io.lce_local)),
    .rd_tags_o(rd_tags),
    .rd_states_o(rd_states),
    .wr_v_i(seg_io.w_v),
    .wr_set_i(cmd_set),
    .wr_lce_i(seg_io.lce_local),
    .wr_way_i(seg_io.way),
    .wr_tag_v_i(seg_io.cmd == cce_dir_pkg::e_wde_op),
    .wr_tag_i(cmd_tag),
    .wr_state_i(seg_io.coh_state)
  );

  // Lowest valid way whose tag matches wins
  always_comb begin
    row_hit   = 1'b0;
    row_way   = '0;
    row_state = cce_dir_pkg::e_COH_I;
    for (int w = `CCE_ASSOC - 1; w >= 0; w--) begin
      if (rd_states[w] != cce_dir_pkg::e_COH_I && rd_tags[w] == tag_q) begin
        row_hit   = 1'b1;
        row_way   = `CCE_WAY_WIDTH'(w);
        row_state = rd_states[w];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_q     <= e_idle;
      cnt_q       <= '0;
      sharers_v_q <= 1'b1;
      hits_q      <= '0;
      lru_own_q   <= 1'b0;
    end else if (in_group) begin
      hits_q[cnt_q] <= row_hit;
      cnt_q         <= cnt_q + 1'b1;
      if (last_row) begin
        state_q     <= e_done_group;
        sharers_v_q <= 1'b1;
      end
    end else if (accept_rdw) begin
      state_q     <= e_read_group;
      cnt_q       <= '0;
      sharers_v_q <= 1'b0;
      hits_q      <= '0;
      lru_own_q   <= seg_io.r_lru_v;
    end else if (accept_rde) begin
      state_q <= e_read_entry;
    end else begin
      state_q <= e_idle;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!in_group && seg_io.r_v) begin
      tag_q     <= cmd_tag;
      set_q     <= cmd_set;
      lce_q     <= seg_io.lce_local;
      way_q     <= seg_io.way;
      lru_way_q <= seg_io.lru_way;
      gpr_q     <= seg_io.addr_dst_gpr;
    end
    if (in_group) begin
      ways_q[cnt_q]   <= row_way;
      states_q[cnt_q] <= row_state;
      // Victim entry of the requesting LCE
      if (cnt_q == lce_q) begin
        lru_tag_q   <= rd_tags[lru_way_q];
        lru_state_q <= rd_states[lru_way_q];
      end
    end
  end

  assign seg_io.busy             = in_group;
  assign seg_io.sharers_v        = sharers_v_q;
  assign seg_io.sharers_hits     = hits_q;
  assign seg_io.sharers_ways     = ways_q;
  assign seg_io.sharers_states   = states_q;
  assign seg_io.lru_v            = (state_q == e_done_group) && lru_own_q;
  assign seg_io.lru_state        = lru_state_q;
  assign seg_io.lru_addr         = {lru_tag_q, set_q, {`CCE_BLOCK_OFFSET{1'b0}}};
  assign seg_io.addr_v           = (state_q == e_read_entry);
  assign seg_io.addr_out         = {rd_tags[way_q], set_q, {`CCE_BLOCK_OFFSET{1'b0}}};
  assign seg_io.addr_dst_gpr_out = gpr_q;

  // Caller must hold off while a way-group read is in flight
  no_cmd_while_busy: assert property (@(posedge clk_i) disable iff (!reset_i)
    seg_io.busy |-> !(seg_io.r_v || seg_io.w_v))
    else $error("Directory command issued while segment busy");

  no_read_and_write: assert property (@(posedge clk_i) disable iff (!reset_i)
    !(seg_io.r_v && seg_io.w_v))
    else $error("Read and write strobes high in the same cycle");

endmodule

// File: flist.f
+incdir+common
common/cce_dir_pkg.sv
common/dir_seg_if.sv
dir_segment/dir_entry_store.sv
dir_segment/dir_segment.sv
rtl/cce_dir.sv
test/cce_dir_tb.sv

// File: rtl/cce_dir.sv
`timescale 1ns/100ps
`include "cce_dir_consts.svh"

module cce_dir (
  input  logic                                           clk_i,
  input  logic                                           reset_i,

  input  logic [`CCE_PADDR_WIDTH-1:0]                    addr_i,
  input  logic [`CCE_LCE_ID_WIDTH-1:0]                   lce_i,
  input  logic [`CCE_WAY_WIDTH-1:0]                      way_i,
  input  logic [`CCE_WAY_WIDTH-1:0]                      lru_way_i,
  input  cce_dir_pkg::coh_state_e                        coh_state_i,
  input  cce_dir_pkg::opd_gpr_e                          addr_dst_gpr_i,
  input  cce_dir_pkg::dir_op_e                           cmd_i,
  input  logic                                           r_v_i,
  input  logic                                           w_v_i,

  output logic                                           busy_o,
  output logic                                           sharers_v_o,
  output logic [`CCE_NUM_LCE-1:0]                        sharers_hits_o,
  output logic [`CCE_NUM_LCE-1:0][`CCE_WAY_WIDTH-1:0]    sharers_ways_o,
  output cce_dir_pkg::coh_state_e [`CCE_NUM_LCE-1:0]     sharers_coh_states_o,

  output logic                                           lru_v_o,
  output cce_dir_pkg::coh_state_e                        lru_coh_state_o,
  output logic [`CCE_PADDR_WIDTH-1:0]                    lru_addr_o,

  output logic                                           addr_v_o,
  output logic [`CCE_PADDR_WIDTH-1:0]                    addr_o,
  output cce_dir_pkg::opd_gpr_e                          addr_dst_gpr_o
);

  localparam int sets_lp       = 1 << `CCE_SET_WIDTH;
  localparam int core_lce_w_lp = (`CCE_NUM_CORE > 1) ? $clog2(`CCE_NUM_CORE) : 1;
  localparam int acc_lce_w_lp  = (`CCE_NUM_CACC > 1) ? $clog2(`CCE_NUM_CACC) : 1;

  // LCE id classification
  wire lce_is_acache = (lce_i >= `CCE_LCE_ID_WIDTH'(`CCE_ACC_LCE_BASE));
  wire lce_is_icache = !lce_is_acache && !lce_i[0];
  wire lce_is_dcache = !lce_is_acache && lce_i[0];
  wire is_rdw        = (cmd_i == cce_dir_pkg::e_rdw_op);
  wire is_rde        = (cmd_i == cce_dir_pkg::e_rde_op);

  wire [core_lce_w_lp-1:0] core_lce = lce_i[1 +: core_lce_w_lp];
  wire [acc_lce_w_lp-1:0]  acc_lce  =
    acc_lce_w_lp'(lce_i - `CCE_LCE_ID_WIDTH'(`CCE_ACC_LCE_BASE));

  dir_seg_if #(.seg_lce_p(`CCE_NUM_CORE)) icache_if ();
  dir_seg_if #(.seg_lce_p(`CCE_NUM_CORE)) dcache_if ();
  dir_seg_if #(.seg_lce_p(`CCE_NUM_CACC)) acache_if ();

  // rdw goes to every segment, everything else only to the owner
  assign icache_if.lce_local = core_lce;
  assign icache_if.r_v       = r_v_i && (is_rdw || (is_rde && lce_is_icache));
  assign icache_if.r_lru_v   = lce_is_icache;
  assign icache_if.w_v       = w_v_i && lce_is_icache;

  assign dcache_if.lce_local = core_lce;
  assign dcache_if.r_v       = r_v_i && (is_rdw || (is_rde && lce_is_dcache));
  assign dcache_if.r_lru_v   = lce_is_dcache;
  assign dcache_if.w_v       = w_v_i && lce_is_dcache;

  assign acache_if.lce_local = acc_lce;
  assign acache_if.r_v       = r_v_i && (is_rdw || (is_rde && lce_is_acache));
  assign acache_if.r_lru_v   = lce_is_acache;
  assign acache_if.w_v       = w_v_i && lce_is_acache;

  assign {icache_if.addr, dcache_if.addr, acache_if.addr} = {3{addr_i}};
  assign {icache_if.way, dcache_if.way, acache_if.way} = {3{way_i}};
  assign {icache_if.lru_way, dcache_if.lru_way, acache_if.lru_way} = {3{lru_way_i}};
  assign icache_if.coh_state    = coh_state_i;
  assign dcache_if.coh_state    = coh_state_i;
  assign acache_if.coh_state    = coh_state_i;
  assign icache_if.addr_dst_gpr = addr_dst_gpr_i;
  assign dcache_if.addr_dst_gpr = addr_dst_gpr_i;
  assign acache_if.addr_dst_gpr = addr_dst_gpr_i;
  assign icache_if.cmd          = cmd_i;
  assign dcache_if.cmd          = cmd_i;
  assign acache_if.cmd          = cmd_i;

  dir_segment #(.seg_lce_p(`CCE_NUM_CORE), .sets_p(sets_lp)) icache_seg_i (
    .clk_i(clk_i), .reset_i(reset_i), .seg_io(icache_if.seg)
  );
  dir_segment #(.seg_lce_p(`CCE_NUM_CORE), .sets_p(sets_lp)) dcache_seg_i (
    .clk_i(clk_i), .reset_i(reset_i), .seg_io(dcache_if.seg)
  );
  dir_segment #(.seg_lce_p(`CCE_NUM_CACC), .sets_p(sets_lp)) acache_seg_i (
    .clk_i(clk_i), .reset_i(reset_i), .seg_io(acache_if.seg)
  );

  assign busy_o      = icache_if.busy | dcache_if.busy | acache_if.busy;
  assign sharers_v_o = icache_if.sharers_v & dcache_if.sharers_v & acache_if.sharers_v;

  // I$ to even ids, D$ to odd ids, A$ from the accelerator base up
  always_comb begin
    sharers_hits_o = '0;
    sharers_ways_o = '0;
    for (int i = 0; i < `CCE_NUM_LCE; i++) begin
      sharers_coh_states_o[i] = cce_dir_pkg::e_COH_I;
    end
    for (int i = 0; i < `CCE_NUM_CORE; i++) begin
      sharers_hits_o[2*i]         = icache_if.sharers_hits[i];
      sharers_ways_o[2*i]         = icache_if.sharers_ways[i];
      sharers_coh_states_o[2*i]   = icache_if.sharers_states[i];
      sharers_hits_o[2*i+1]       = dcache_if.sharers_hits[i];
      sharers_ways_o[2*i+1]       = dcache_if.sharers_ways[i];
      sharers_coh_states_o[2*i+1] = dcache_if.sharers_states[i];
    end
    for (int i = 0; i < `CCE_NUM_CACC; i++) begin
      sharers_hits_o[`CCE_ACC_LCE_BASE+i]       = acache_if.sharers_hits[i];
      sharers_ways_o[`CCE_ACC_LCE_BASE+i]       = acache_if.sharers_ways[i];
      sharers_coh_states_o[`CCE_ACC_LCE_BASE+i] = acache_if.sharers_states[i];
    end
  end

  assign lru_v_o = icache_if.lru_v | dcache_if.lru_v | acache_if.lru_v;
  assign lru_coh_state_o = icache_if.lru_v ? icache_if.lru_state
                         : dcache_if.lru_v ? dcache_if.lru_state
                         : acache_if.lru_v ? acache_if.lru_state
                         : cce_dir_pkg::e_COH_I;
  assign lru_addr_o = icache_if.lru_v ? icache_if.lru_addr
                    : dcache_if.lru_v ? dcache_if.lru_addr
                    : acache_if.lru_v ? acache_if.lru_addr
                    : '0;

  assign addr_v_o = icache_if.addr_v | dcache_if.addr_v | acache_if.addr_v;
  assign addr_o = icache_if.addr_v ? icache_if.addr_out
                : dcache_if.addr_v ? dcache_if.addr_out
                : acache_if.addr_v ? acache_if.addr_out
                : '0;
  assign addr_dst_gpr_o = icache_if.addr_v ? icache_if.addr_dst_gpr_out
                        : dcache_if.addr_v ? dcache_if.addr_dst_gpr_out
                        : acache_if.addr_v ? acache_if.addr_dst_gpr_out
                        : cce_dir_pkg::e_opd_r0;

  // Priority merge relies on a single answering segment
  seg_lru_onehot: assert property (@(posedge clk_i) disable iff (!reset_i)
    $onehot0({icache_if.lru_v, dcache_if.lru_v, acache_if.lru_v}))
    else $error("More than one segment drives LRU in the same cycle");

  seg_addr_onehot: assert property (@(posedge clk_i) disable iff (!reset_i)
    $onehot0({icache_if.addr_v, dcache_if.addr_v, acache_if.addr_v}))
    else $error("More than one segment drives an entry address in the same cycle");

endmodule

// File: test/cce_dir_stim.txt
# cmd lce addr way lru_way state gpr | hits ways states lru_state lru_addr ret_addr ret_gpr
# all hex; cmd 0 rdw 1 rde 2 wde 3 wds; states are 3 bits per LCE with LCE 0 lowest
# empty directory after reset
0 0 1234 0 0 0 0 00 00 0000 0 0000 0000 0
0 4 ffff 0 1 0 0 00 00 0000 0 01c0 0000 0
1 0 12f4 1 0 0 3 00 00 0000 0 0000 00c0 3
# write D$ LCE 3 way 1 then read the entry back
2 3 5553 1 0 3 0 00 00 0000 0 0000 0000 0
1 3 5540 1 0 0 5 00 00 0000 0 0000 5540 5
# same block shared by LCE 0, 2 and 4, other tag in LCE 1
2 0 2680 0 0 1 0 00 00 0000 0 0000 0000 0
2 2 2680 1 0 1 0 00 00 0000 0 0000 0000 0
2 4 2680 0 0 1 0 00 00 0000 0 0000 0000 0
2 1 2880 0 0 2 0 00 00 0000 0 0000 0000 0
0 0 2680 0 1 0 0 15 04 1041 0 0080 0000 0
# state-only write drops LCE 2, tag stays
3 2 7e80 1 0 0 0 00 00 0000 0 0000 0000 0
0 2 2680 0 1 0 0 11 00 1001 0 2680 0000 0
1 2 2680 1 0 0 2 00 00 0000 0 0000 2680 2
# victim entry of D$ LCE 1
0 1 2680 0 0 0 0 11 00 1001 2 2880 0000 0
0 3 5540 0 1 0 0 08 08 0600 3 5540 0000 0
# neighbouring sets untouched
0 4 2640 0 0 0 0 00 00 0000 0 0040 0000 0
0 0 26c0 0 0 0 0 00 00 0000 0 00c0 0000 0
# two valid ways in A$, lowest one reported
2 4 2680 1 0 4 0 00 00 0000 0 0000 0000 0
0 4 2680 0 1 0 0 11 00 1001 4 2680 0000 0
3 4 2680 0 0 0 0 00 00 0000 0 0000 0000 0
0 4 2680 0 0 0 0 11 10 4001 0 2680 0000 0
1 4 2680 1 0 0 7 00 00 0000 0 0000 2680 7
1 1 2880 0 0 0 1 00 00 0000 0 0000 2880 1
# A$ entry in set 0
2 4 fe00 1 0 5 0 00 00 0000 0 0000 0000 0
0 0 fe00 0 0 0 0 10 10 5000 0 0000 0000 0
0 0 1234 0 1 0 0 00 00 0000 0 0000 0000 0
1 4 fe3f 1 0 0 6 00 00 0000 0 0000 fe00 6

// File: test/cce_dir_tb.sv
`timescale 1ns/100ps
`include "cce_dir_consts.svh"

module cce_dir_tb;

  localparam int reset_cycles_lp    = 4;
  localparam int cycles_per_line_lp = 20;
  localparam int ways_w_lp          = `CCE_NUM_LCE * `CCE_WAY_WIDTH;
  localparam int states_w_lp        = 3 * `CCE_NUM_LCE;

  // One stimulus line with its expected answers
  typedef struct packed {
    logic [1:0]                   cmd;
    logic [`CCE_LCE_ID_WIDTH-1:0] lce;
    logic [`CCE_PADDR_WIDTH-1:0]  addr;
    logic [`CCE_WAY_WIDTH-1:0]    way;
    logic [`CCE_WAY_WIDTH-1:0]    lru_way;
    logic [2:0]                   state;
    logic [2:0]                   gpr;
    logic [`CCE_NUM_LCE-1:0]      hits;
    logic [ways_w_lp-1:0]         ways;
    logic [states_w_lp-1:0]       states;
    logic [2:0]                   lru_state;
    logic [`CCE_PADDR_WIDTH-1:0]  lru_addr;
    logic [`CCE_PADDR_WIDTH-1:0]  ret_addr;
    logic [2:0]                   ret_gpr;
  } stim_line_t;

  logic                                         clk_i;
  logic                                         reset_i;
  logic [`CCE_PADDR_WIDTH-1:0]                  addr_i;
  logic [`CCE_LCE_ID_WIDTH-1:0]                 lce_i;
  logic [`CCE_WAY_WIDTH-1:0]                    way_i;
  logic [`CCE_WAY_WIDTH-1:0]                    lru_way_i;
  cce_dir_pkg::coh_state_e                      coh_state_i;
  cce_dir_pkg::opd_gpr_e                        addr_dst_gpr_i;
  cce_dir_pkg::dir_op_e                         cmd_i;
  logic                                         r_v_i;
  logic                                         w_v_i;
  logic                                         busy_o;
  logic                                         sharers_v_o;
  logic [`CCE_NUM_LCE-1:0]                      sharers_hits_o;
  logic [`CCE_NUM_LCE-1:0][`CCE_WAY_WIDTH-1:0]  sharers_ways_o;
  cce_dir_pkg::coh_state_e [`CCE_NUM_LCE-1:0]   sharers_coh_states_o;
  logic                                         lru_v_o;
  cce_dir_pkg::coh_state_e                      lru_coh_state_o;
  logic [`CCE_PADDR_WIDTH-1:0]                  lru_addr_o;
  logic                                         addr_v_o;
  logic [`CCE_PADDR_WIDTH-1:0]                  addr_o;
  cce_dir_pkg::opd_gpr_e                        addr_dst_gpr_o;

  stim_line_t stim_q [$];
  bit         stim_loaded;

  cce_dir dut_i (
    .clk_i(clk_i), .reset_i(reset_i), .addr_i(addr_i), .lce_i(lce_i), .way_i(way_i),
    .lru_way_i(lru_way_i), .coh_state_i(coh_state_i), .addr_dst_gpr_i(addr_dst_gpr_i),
    .cmd_i(cmd_i), .r_v_i(r_v_i), .w_v_i(w_v_i), .busy_o(busy_o), .sharers_v_o(sharers_v_o),
    .sharers_hits_o(sharers_hits_o), .sharers_ways_o(sharers_ways_o),
    .sharers_coh_states_o(sharers_coh_states_o), .lru_v_o(lru_v_o),
    .lru_coh_state_o(lru_coh_state_o), .lru_addr_o(lru_addr_o), .addr_v_o(addr_v_o),
    .addr_o(addr_o), .addr_dst_gpr_o(addr_dst_gpr_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else stop_with_failure($sformatf("FAILED %s expected %h actual %h",
                                       name, expected, actual));
  endtask

  // Comment and blank lines scan no fields and are skipped
  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    stim_line_t  s;
    logic [31:0] f_cmd, f_lce, f_addr, f_way, f_lru_way, f_state, f_gpr;
    logic [31:0] f_hits, f_ways, f_states, f_lru_state, f_lru_addr, f_ret_addr, f_ret_gpr;
    fd = $fopen("test/cce_dir_stim.txt", "r");
    assert (fd != 0) else stop_with_failure("could not open test/cce_dir_stim.txt");
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f_cmd, f_lce, f_addr, f_way, f_lru_way, f_state, f_gpr,
                  f_hits, f_ways, f_states, f_lru_state, f_lru_addr, f_ret_addr, f_ret_gpr);
      if (n == 14) begin
        s.cmd       = f_cmd[1:0];
        s.lce       = f_lce[`CCE_LCE_ID_WIDTH-1:0];
        s.addr      = f_addr[`CCE_PADDR_WIDTH-1:0];
        s.way       = f_way[`CCE_WAY_WIDTH-1:0];
        s.lru_way   = f_lru_way[`CCE_WAY_WIDTH-1:0];
        s.state     = f_state[2:0];
        s.gpr       = f_gpr[2:0];
        s.hits      = f_hits[`CCE_NUM_LCE-1:0];
        s.ways      = f_ways[ways_w_lp-1:0];
        s.states    = f_states[states_w_lp-1:0];
        s.lru_state = f_lru_state[2:0];
        s.lru_addr  = f_lru_addr[`CCE_PADDR_WIDTH-1:0];
        s.ret_addr  = f_ret_addr[`CCE_PADDR_WIDTH-1:0];
        s.ret_gpr   = f_ret_gpr[2:0];
        stim_q.push_back(s);
      end else begin
        assert (n <= 0) else stop_with_failure("stimulus file has a malformed line");
      end
    end
    $fclose(fd);
  endtask

  task automatic release_strobes();
    r_v_i = 1'b0;
    w_v_i = 1'b0;
  endtask

  task automatic apply_command(input stim_line_t s);
    cce_dir_pkg::dir_op_e op;
    op             = cce_dir_pkg::dir_op_e'(s.cmd);
    cmd_i          = op;
    lce_i          = s.lce;
    addr_i         = s.addr;
    way_i          = s.way;
    lru_way_i      = s.lru_way;
    coh_state_i    = cce_dir_pkg::coh_state_e'(s.state);
    addr_dst_gpr_i = cce_dir_pkg::opd_gpr_e'(s.gpr);
    r_v_i          = (op == cce_dir_pkg::e_rdw_op) || (op == cce_dir_pkg::e_rde_op);
    w_v_i          = (op == cce_dir_pkg::e_wde_op) || (op == cce_dir_pkg::e_wds_op);
  endtask

  // Entered and left at the drive point 2 ns after a rising edge
  task automatic run_line(input stim_line_t s);
    cce_dir_pkg::dir_op_e op;
    int                   lru_pulses;
    logic [31:0]          lru_state_seen;
    logic [31:0]          lru_addr_seen;
    op             = cce_dir_pkg::dir_op_e'(s.cmd);
    lru_pulses     = 0;
    lru_state_seen = '0;
    lru_addr_seen  = '0;
    check_value("busy_o", 32'd0, 32'(busy_o));
    check_value("addr_v_o", 32'd0, 32'(addr_v_o));
    apply_command(s);
    @(posedge clk_i);
    #1;
    if (op == cce_dir_pkg::e_rdw_op) begin
      check_value("busy_o", 32'd1, 32'(busy_o));
      check_value("sharers_v_o", 32'd0, 32'(sharers_v_o));
    end else begin
      check_value("busy_o", 32'd0, 32'(busy_o));
      check_value("lru_v_o", 32'd0, 32'(lru_v_o));
      check_value("addr_v_o", 32'(op == cce_dir_pkg::e_rde_op), 32'(addr_v_o));
      if (op == cce_dir_pkg::e_rde_op) begin
        check_value("addr_o", 32'(s.ret_addr), 32'(addr_o));
        check_value("addr_dst_gpr_o", 32'(s.ret_gpr), 32'(addr_dst_gpr_o));
      end
    end
    #1;
    release_strobes();
    if (op == cce_dir_pkg::e_rdw_op) begin
      while (!(sharers_v_o && !busy_o)) begin
        @(posedge clk_i);
        #1;
        if (lru_v_o) begin
          lru_pulses++;
          lru_state_seen = 32'(lru_coh_state_o);
          lru_addr_seen  = 32'(lru_addr_o);
        end
        #1;
      end
      assert (lru_pulses == 1)
        else stop_with_failure($sformatf("lru_v_o pulsed %0d times in one way-group read",
                                         lru_pulses));
      check_value("sharers_hits_o", 32'(s.hits), 32'(sharers_hits_o));
      check_value("sharers_ways_o", 32'(s.ways), 32'(sharers_ways_o));
      check_value("sharers_coh_states_o", 32'(s.states), 32'(sharers_coh_states_o));
      check_value("lru_coh_state_o", 32'(s.lru_state), lru_state_seen);
      check_value("lru_addr_o", 32'(s.lru_addr), lru_addr_seen);
    end else if (op == cce_dir_pkg::e_rde_op) begin
      // Entry answer lasts a single cycle
      @(posedge clk_i);
      #1;
      check_value("addr_v_o", 32'd0, 32'(addr_v_o));
      #1;
    end
  endtask

  initial begin
    stim_loaded    = 1'b0;
    reset_i        = 1'b0;
    addr_i         = '0;
    lce_i          = '0;
    way_i          = '0;
    lru_way_i      = '0;
    coh_state_i    = cce_dir_pkg::e_COH_I;
    addr_dst_gpr_i = cce_dir_pkg::e_opd_r0;
    cmd_i          = cce_dir_pkg::e_rdw_op;
    r_v_i          = 1'b0;
    w_v_i          = 1'b0;
    load_stimulus();
    stim_loaded = 1'b1;
    repeat (reset_cycles_lp) @(posedge clk_i);
    #1;
    check_value("busy_o", 32'd0, 32'(busy_o));
    check_value("sharers_v_o", 32'd1, 32'(sharers_v_o));
    check_value("lru_v_o", 32'd0, 32'(lru_v_o));
    check_value("addr_v_o", 32'd0, 32'(addr_v_o));
    #1;
    reset_i = 1'b1;
    foreach (stim_q[i]) begin
      run_line(stim_q[i]);
    end
    if (stim_q.size() > 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_with_failure("stimulus file held no command lines");
    end
  end

  // Watchdog sized from the number of stimulus lines
  initial begin
    wait (stim_loaded);
    repeat (reset_cycles_lp + cycles_per_line_lp * (stim_q.size() + 1)) @(posedge clk_i);
    stop_with_failure("simulation timed out before all stimulus lines completed");
  end

endmodule
